// File: hw/cache_geom_pkg.sv
// ----------------------------------------------------------
// Geometry of the direct-mapped L1 data cache: sizes, the
// address field widths and types, and the controller states.
// Import wherever a line index, offset or tag is handled.
// ----------------------------------------------------------

package cache_geom_pkg;

    // capacity and line shape
    localparam int CACHE_BYTES = 1024;
    localparam int LINE_WORDS  = 4;
    localparam int N_LINES     = CACHE_BYTES / (LINE_WORDS * 4);

    // address split, top down: tag | index | offset | 2 byte bits
    localparam int INDEX_BITS  = $clog2(N_LINES);
    localparam int OFFSET_BITS = $clog2(LINE_WORDS);
    localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS - 2;

    typedef logic [INDEX_BITS-1:0]  index_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [TAG_BITS-1:0]    tag_t;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        RESPOND,
        WRITE_BACK,
        FILL,
        FLUSH_SCAN,
        FLUSH_WRITE
    } ctrl_state_t;

endpackage

// File: hw/bus_pkg.sv
// ----------------------------------------------------------
// Wishbone word, address and byte-select types shared by the
// processor and memory ports, plus the start of the uncached
// address window.
// ----------------------------------------------------------

package bus_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  sel_t;

    // everything from here up bypasses the cache
    localparam addr_t UNCACHED_BASE = 32'hF000_0000;

endpackage

// File: hw/tag_store.sv
// ----------------------------------------------------------
// Per-line valid, dirty and tag state. Lookup is combinational
// on lookup_index; one update per clock through the upd_ port.
// ----------------------------------------------------------

`timescale 1ns/1ps

module tag_store (
    input  logic                  CLK,
    input  logic                  nRST,
    input  cache_geom_pkg::index_t lookup_index,
    input  cache_geom_pkg::tag_t   lookup_tag,
    input  logic                  upd_en,
    input  cache_geom_pkg::index_t upd_index,
    input  cache_geom_pkg::tag_t   upd_tag,
    input  logic                  upd_valid,
    input  logic                  upd_dirty,
    output logic                  hit,
    output logic                  victim_dirty,
    output cache_geom_pkg::tag_t   victim_tag
);
    import cache_geom_pkg::*;

    logic [N_LINES-1:0] valid_q;
    logic [N_LINES-1:0] dirty_q;
    tag_t               tag_q [N_LINES];

    // status bits come out of reset cleared
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (upd_en) begin
            valid_q[upd_index] <= upd_valid;
            dirty_q[upd_index] <= upd_dirty;
        end
    end

    // tags only mean something while valid
    always_ff @(posedge CLK) begin
        if (upd_en) begin
            tag_q[upd_index] <= upd_tag;
        end
    end

    assign hit = valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);

    // a line needs writing back only if it holds live data
    assign victim_dirty = valid_q[lookup_index] && dirty_q[lookup_index];
    assign victim_tag   = tag_q[lookup_index];

endmodule

// File: hw/data_store.sv
// ----------------------------------------------------------
// Line data array, 64 lines of four words. Reads are
// combinational; writes land on the next edge and touch only
// the bytes set in wr_sel.
// ----------------------------------------------------------

`timescale 1ns/1ps

module data_store (
    input  logic                    CLK,
    input  cache_geom_pkg::index_t  rd_index,
    input  cache_geom_pkg::offset_t rd_offset,
    input  logic                    wr_en,
    input  cache_geom_pkg::index_t  wr_index,
    input  cache_geom_pkg::offset_t wr_offset,
    input  bus_pkg::word_t          wr_word,
    input  bus_pkg::sel_t           wr_sel,
    output bus_pkg::word_t          rd_word
);
    import cache_geom_pkg::*;
    import bus_pkg::*;

    word_t lines_q [N_LINES][LINE_WORDS];

    // byte lanes written independently
    always_ff @(posedge CLK) begin
        if (wr_en) begin
            for (int b = 0; b < $bits(sel_t); b++) begin
                if (wr_sel[b]) begin
                    lines_q[wr_index][wr_offset][8*b +: 8] <= wr_word[8*b +: 8];
                end
            end
        end
    end

    assign rd_word = lines_q[rd_index][rd_offset];

endmodule

// File: hw/cache_ctrl.sv
// ----------------------------------------------------------
// Cache controller FSM. Serves hits, uncached pass-through,
// victim write-back, line fill and the flush walk, driving
// the tag and data stores and the Wishbone master port.
// ----------------------------------------------------------

`timescale 1ns/1ps

module cache_ctrl (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    cpu_cyc,
    input  logic                    cpu_stb,
    input  logic                    cpu_we,
    input  bus_pkg::addr_t          cpu_adr,
    input  bus_pkg::word_t          cpu_dat_w,
    input  bus_pkg::sel_t           cpu_sel,
    input  logic                    flush,
    input  bus_pkg::word_t          mem_dat_r,
    input  logic                    mem_ack,
    input  logic                    hit,
    input  logic                    victim_dirty,
    input  cache_geom_pkg::tag_t    victim_tag,
    input  bus_pkg::word_t          rd_word,
    output bus_pkg::word_t          cpu_dat_r,
    output logic                    cpu_ack,
    output logic                    flush_done,
    output logic                    mem_cyc,
    output logic                    mem_stb,
    output logic                    mem_we,
    output bus_pkg::addr_t          mem_adr,
    output bus_pkg::word_t          mem_dat_w,
    output bus_pkg::sel_t           mem_sel,
    output cache_geom_pkg::index_t  lookup_index,
    output cache_geom_pkg::tag_t    lookup_tag,
    output cache_geom_pkg::index_t  rd_index,
    output cache_geom_pkg::offset_t rd_offset,
    output logic                    upd_en,
    output cache_geom_pkg::index_t  upd_index,
    output cache_geom_pkg::tag_t    upd_tag,
    output logic                    upd_valid,
    output logic                    upd_dirty,
    output logic                    wr_en,
    output cache_geom_pkg::index_t  wr_index,
    output cache_geom_pkg::offset_t wr_offset,
    output bus_pkg::word_t          wr_word,
    output bus_pkg::sel_t           wr_sel
);
    import cache_geom_pkg::*;
    import bus_pkg::*;

    ctrl_state_t state;
    offset_t     word_cnt;
    index_t      line_cnt;
    logic        flush_pend;
    word_t       pass_data;
    tag_t        req_tag;
    index_t      req_index;
    offset_t     req_offset;
    logic        req_live;
    logic        uncached;
    logic        flushing;
    logic        last_word;
    logic        last_line;
    logic        start_flush;

    // the core holds the request steady, so decode it straight off the bus
    assign req_tag    = cpu_adr[$bits(addr_t)-1 -: TAG_BITS];
    assign req_index  = cpu_adr[OFFSET_BITS + 2 +: INDEX_BITS];
    assign req_offset = cpu_adr[2 +: OFFSET_BITS];
    assign uncached   = cpu_adr >= UNCACHED_BASE;

    // no new start while the previous ack is still on the bus
    assign req_live    = cpu_cyc && cpu_stb && !cpu_ack;
    assign flushing    = (state == FLUSH_SCAN) || (state == FLUSH_WRITE);
    assign last_word   = mem_ack && (word_cnt == offset_t'(LINE_WORDS - 1));
    assign last_line   = line_cnt == index_t'(N_LINES - 1);
    assign start_flush = (state == IDLE) && (flush || flush_pend);

    // flush walk reads the scanned line, everything else the request line
    assign lookup_index = flushing ? line_cnt : req_index;
    assign lookup_tag   = req_tag;
    assign rd_index     = lookup_index;
    assign rd_offset    = (state == RESPOND) ? req_offset : word_cnt;
    assign upd_index    = lookup_index;
    assign upd_tag      = req_tag;
    assign wr_index     = lookup_index;

    assign cpu_dat_r = (state == RESPOND) ? rd_word : pass_data;

    // memory master port
    always_comb begin
        mem_cyc   = 1'b0;
        mem_we    = 1'b0;
        mem_adr   = {victim_tag, lookup_index, word_cnt, 2'b00};
        mem_dat_w = rd_word;
        mem_sel   = '1;
        case (state)
            RESPOND: begin
                if (uncached) begin
                    mem_cyc   = 1'b1;
                    mem_we    = cpu_we;
                    mem_adr   = cpu_adr;
                    mem_dat_w = cpu_dat_w;
                    mem_sel   = cpu_sel;
                end
            end
            WRITE_BACK, FLUSH_WRITE: begin
                mem_cyc = 1'b1;
                mem_we  = 1'b1;
            end
            FILL: begin
                mem_cyc = 1'b1;
                mem_adr = {req_tag, req_index, word_cnt, 2'b00};
            end
            default: ;
        endcase
    end

    assign mem_stb = mem_cyc;

    // tag and data store updates
    always_comb begin
        upd_en    = 1'b0;
        upd_valid = 1'b0;
        upd_dirty = 1'b0;
        wr_en     = 1'b0;
        wr_offset = req_offset;
        wr_word   = cpu_dat_w;
        wr_sel    = cpu_sel;
        case (state)
            RESPOND: begin
                // write hit marks the line dirty
                if (!uncached && cpu_we) begin
                    upd_en    = 1'b1;
                    upd_valid = 1'b1;
                    upd_dirty = 1'b1;
                    wr_en     = 1'b1;
                end
            end
            FILL: begin
                wr_en     = mem_ack;
                wr_offset = word_cnt;
                wr_sel    = '1;
                wr_word   = mem_dat_r;
                // fold the pending write into its word as it arrives
                if (cpu_we && (word_cnt == req_offset)) begin
                    for (int b = 0; b < $bits(sel_t); b++) begin
                        if (cpu_sel[b]) begin
                            wr_word[8*b +: 8] = cpu_dat_w[8*b +: 8];
                        end
                    end
                end
                upd_en    = last_word;
                upd_valid = 1'b1;
            end
            FLUSH_SCAN: upd_en = !victim_dirty;
            FLUSH_WRITE: upd_en = last_word;
            default: ;
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state      <= IDLE;
            word_cnt   <= '0;
            line_cnt   <= '0;
            flush_pend <= 1'b0;
            cpu_ack    <= 1'b0;
            flush_done <= 1'b0;
        end else begin
            cpu_ack    <= 1'b0;
            flush_done <= 1'b0;
            if (start_flush) begin
                flush_pend <= 1'b0;
            end else if (flush) begin
                flush_pend <= 1'b1;
            end
            // line transfers always run all four words, so it wraps to 0
            if (mem_ack && state != RESPOND) begin
                word_cnt <= word_cnt + 1'b1;
            end
            case (state)
                IDLE: begin
                    if (start_flush) begin
                        line_cnt <= '0;
                        state    <= FLUSH_SCAN;
                    end else if (req_live) begin
                        if (uncached) begin
                            state <= RESPOND;
                        end else if (hit) begin
                            cpu_ack <= 1'b1;
                            state   <= RESPOND;
                        end else if (victim_dirty) begin
                            state <= WRITE_BACK;
                        end else begin
                            state <= FILL;
                        end
                    end
                end
                RESPOND: begin
                    if (!uncached) begin
                        state <= IDLE;
                    end else if (mem_ack) begin
                        cpu_ack <= 1'b1;
                        state   <= IDLE;
                    end
                end
                WRITE_BACK: begin
                    if (last_word) begin
                        state <= FILL;
                    end
                end
                FILL: begin
                    // back to IDLE, where the request now hits
                    if (last_word) begin
                        state <= IDLE;
                    end
                end
                FLUSH_SCAN: begin
                    if (victim_dirty) begin
                        state <= FLUSH_WRITE;
                    end else if (last_line) begin
                        flush_done <= 1'b1;
                        state      <= IDLE;
                    end else begin
                        line_cnt <= line_cnt + 1'b1;
                    end
                end
                FLUSH_WRITE: begin
                    if (last_word && last_line) begin
                        flush_done <= 1'b1;
                        state      <= IDLE;
                    end else if (last_word) begin
                        line_cnt <= line_cnt + 1'b1;
                        state    <= FLUSH_SCAN;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // uncached read data, held for the ack cycle
    always_ff @(posedge CLK) begin
        if (state == RESPOND && mem_ack) begin
            pass_data <= mem_dat_r;
        end
    end

endmodule

// File: hw/l1_cache.sv
// ----------------------------------------------------------
// L1 data cache top level. Wishbone classic slave toward the
// core, Wishbone classic master toward memory, and a flush
// pulse input answered by a one-cycle flush_done.
// ----------------------------------------------------------

`timescale 1ns/1ps

module l1_cache (
    input  logic           CLK,
    input  logic           nRST,
    input  logic           cpu_cyc,
    input  logic           cpu_stb,
    input  logic           cpu_we,
    input  bus_pkg::addr_t cpu_adr,
    input  bus_pkg::word_t cpu_dat_w,
    input  bus_pkg::sel_t  cpu_sel,
    input  logic           flush,
    input  bus_pkg::word_t mem_dat_r,
    input  logic           mem_ack,
    output bus_pkg::word_t cpu_dat_r,
    output logic           cpu_ack,
    output logic           flush_done,
    output logic           mem_cyc,
    output logic           mem_stb,
    output logic           mem_we,
    output bus_pkg::addr_t mem_adr,
    output bus_pkg::word_t mem_dat_w,
    output bus_pkg::sel_t  mem_sel
);
    import cache_geom_pkg::*;
    import bus_pkg::*;

    // lookup side, shared by both stores
    index_t  lookup_index;
    tag_t    lookup_tag;
    index_t  rd_index;
    offset_t rd_offset;
    logic    hit;
    logic    victim_dirty;
    tag_t    victim_tag;
    word_t   rd_word;

    // update side
    logic    upd_en;
    index_t  upd_index;
    tag_t    upd_tag;
    logic    upd_valid;
    logic    upd_dirty;
    logic    wr_en;
    index_t  wr_index;
    offset_t wr_offset;
    word_t   wr_word;
    sel_t    wr_sel;

    tag_store tags0 (.*);

    data_store data0 (.*);

    cache_ctrl ctrl0 (.*);

endmodule

// File: verif/wb_mem_model.sv
// ----------------------------------------------------------
// Wishbone classic slave memory used as backing store in the
// cache testbench. Decodes 1K words of cached space and 1K
// words of the uncached window, acks after 0 to 3 wait cycles.
// ----------------------------------------------------------

`timescale 1ns/1ps

module wb_mem_model (
    input  logic           CLK,
    input  logic           nRST,
    input  logic           cyc,
    input  logic           stb,
    input  logic           we,
    input  bus_pkg::addr_t adr,
    input  bus_pkg::word_t dat_w,
    input  bus_pkg::sel_t  sel,
    output bus_pkg::word_t dat_r,
    output logic           ack
);
    import bus_pkg::*;

    localparam int DEPTH = 2048;

    word_t       mem [DEPTH];
    logic [1:0]  wait_cnt;
    logic [10:0] entry;
    logic        fire;

    // top bit picks the uncached window
    assign entry = {adr[31], adr[11:2]};
    assign fire  = cyc && stb && !ack && (wait_cnt == 2'd0);

    function automatic addr_t entry_addr(input int i);
        addr_t a;
        a        = '0;
        a[31:28] = i[10] ? 4'hF : 4'h0;
        a[11:2]  = i[9:0];
        return a;
    endfunction

    // every address bit reaches the pattern
    function automatic word_t fill_word(input addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h6C3A_95E1;
    endfunction

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = fill_word(entry_addr(i));
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ack      <= 1'b0;
            wait_cnt <= 2'd0;
            dat_r    <= '0;
        end else begin
            ack <= fire;
            if (fire) begin
                dat_r    <= mem[entry];
                // wait states for the next transfer
                wait_cnt <= 2'($urandom_range(3, 0));
            end else if (cyc && stb && !ack) begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

    always @(posedge CLK) begin
        if (fire && we) begin
            for (int b = 0; b < 4; b++) begin
                if (sel[b]) begin
                    mem[entry][8*b +: 8] <= dat_w[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: verif/tb_l1_cache.sv
// ----------------------------------------------------------
// Testbench for the L1 data cache. Random cached and uncached
// requests against a word model, then a flush whose write-back
// is compared with the backing memory, then re-reads.
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_l1_cache;
    import bus_pkg::*;

    localparam int N_ROUNDS      = 2;
    localparam int REQ_PER_ROUND = 100;
    localparam int N_ENTRIES     = 2048;
    localparam int MAX_REREAD    = 64;
    // 2 us per request, a flush line costs at most 21 cycles
    localparam longint TIMEOUT_NS =
        longint'(N_ROUNDS) * (REQ_PER_ROUND + MAX_REREAD) * 2000 + N_ROUNDS * 64 * 21 * 20;

    logic  CLK;
    logic  nRST;
    logic  cpu_cyc;
    logic  cpu_stb;
    logic  cpu_we;
    addr_t cpu_adr;
    word_t cpu_dat_w;
    sel_t  cpu_sel;
    logic  flush;
    word_t cpu_dat_r;
    logic  cpu_ack;
    logic  flush_done;
    logic  mem_cyc;
    logic  mem_stb;
    logic  mem_we;
    addr_t mem_adr;
    word_t mem_dat_w;
    sel_t  mem_sel;
    word_t mem_dat_r;
    logic  mem_ack;

    // what the core should read back, one entry per memory word
    word_t model   [N_ENTRIES];
    logic  written [N_ENTRIES];

    l1_cache dut0 (.*);

    wb_mem_model mem0 (
        .CLK   (CLK),
        .nRST  (nRST),
        .cyc   (mem_cyc),
        .stb   (mem_stb),
        .we    (mem_we),
        .adr   (mem_adr),
        .dat_w (mem_dat_w),
        .sel   (mem_sel),
        .dat_r (mem_dat_r),
        .ack   (mem_ack)
    );

    always #10 CLK = ~CLK;

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("FAIL at time %0t: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("Some tests failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic int entry_of(input addr_t a);
        return {a[31], a[11:2]};
    endfunction

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input sel_t s);
        word_t r;
        r = old_w;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                r[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return r;
    endfunction

    // few tags on few indexes so that lines get evicted
    function automatic addr_t pick_addr();
        logic [5:0] idx;
        if ($urandom_range(7, 0) == 0) begin
            return UNCACHED_BASE + 4 * $urandom_range(7, 0);
        end
        case ($urandom_range(3, 0))
            0: idx = 6'd0;
            1: idx = 6'd1;
            2: idx = 6'd37;
            default: idx = 6'd63;
        endcase
        return {20'd0, 2'($urandom_range(3, 0)), idx, 2'($urandom_range(3, 0)), 2'b00};
    endfunction

    // called on a falling edge, returns on a falling edge
    task automatic do_request(input logic we, input addr_t a, input word_t d, input sel_t s);
        int    e;
        word_t rdata;
        e         = entry_of(a);
        cpu_cyc   = 1'b1;
        cpu_stb   = 1'b1;
        cpu_we    = we;
        cpu_adr   = a;
        cpu_dat_w = d;
        cpu_sel   = s;
        do begin
            @(negedge CLK);
        end while (!cpu_ack);
        rdata = cpu_dat_r;
        if (we) begin
            model[e] = merge_bytes(model[e], d, s);
            if (a >= UNCACHED_BASE) begin
                check_value($sformatf("mem0.mem[%08h]", a), mem0.mem[e], model[e]);
            end else begin
                written[e] = 1'b1;
            end
        end else begin
            check_value($sformatf("cpu_dat_r[%08h]", a), rdata, model[e]);
        end
        // hold through the edge that samples the ack
        @(negedge CLK);
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
        cpu_we  = 1'b0;
    endtask

    task automatic run_flush();
        int done_cnt;
        done_cnt = 0;
        flush    = 1'b1;
        @(negedge CLK);
        flush = 1'b0;
        while (done_cnt == 0) begin
            @(negedge CLK);
            if (flush_done) begin
                done_cnt++;
            end
        end
        repeat (8) begin
            @(negedge CLK);
            if (flush_done) begin
                done_cnt++;
            end
        end
        check_value("flush_done pulses", done_cnt, 1);
        // all dirty data must now sit in memory
        for (int i = 0; i < N_ENTRIES / 2; i++) begin
            check_value($sformatf("mem0.mem[%08h]", i * 4), mem0.mem[i], model[i]);
        end
        for (int i = 0; i < N_ENTRIES / 2; i++) begin
            if (written[i]) begin
                do_request(1'b0, addr_t'(i * 4), '0, 4'hF);
            end
        end
    endtask

    initial begin
        logic  we;
        addr_t a;
        sel_t  s;
        void'($urandom(24));
        CLK       = 1'b0;
        nRST      = 1'b0;
        cpu_cyc   = 1'b0;
        cpu_stb   = 1'b0;
        cpu_we    = 1'b0;
        cpu_adr   = '0;
        cpu_dat_w = '0;
        cpu_sel   = '0;
        flush     = 1'b0;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        check_value("cpu_ack", cpu_ack, 0);
        check_value("mem_cyc", mem_cyc, 0);
        check_value("mem_stb", mem_stb, 0);
        check_value("flush_done", flush_done, 0);
        for (int i = 0; i < N_ENTRIES; i++) begin
            model[i]   = mem0.mem[i];
            written[i] = 1'b0;
        end
        for (int r = 0; r < N_ROUNDS; r++) begin
            for (int n = 0; n < REQ_PER_ROUND; n++) begin
                we = 1'($urandom_range(1, 0));
                a  = pick_addr();
                s  = we ? sel_t'($urandom_range(15, 1)) : 4'hF;
                do_request(we, a, $urandom(), s);
            end
            run_flush();
        end
        $display("All tests passed");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the DUT stopped answering requests or the flush never finished");
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: src.f
hw/cache_geom_pkg.sv
hw/bus_pkg.sv
hw/tag_store.sv
hw/data_store.sv
hw/cache_ctrl.sv
hw/l1_cache.sv
verif/wb_mem_model.sv
verif/tb_l1_cache.sv

// File: Bender.yml
package:
  name: l1_cache

sources:
  # packages first, then the cache from the leaves up
  - files:
      - hw/cache_geom_pkg.sv
      - hw/bus_pkg.sv
      - hw/tag_store.sv
      - hw/data_store.sv
      - hw/cache_ctrl.sv
      - hw/l1_cache.sv
  - target: test
    files:
      - verif/wb_mem_model.sv
      - verif/tb_l1_cache.sv
